// File: Bender.yml
package:
  name: shading_unit

sources:
  - files:
      - rtl/shade_pkg.sv
      - rtl/shade_if.sv
      - rtl/hit_dispatch.sv
      - rtl/ambient_term.sv
      - rtl/diffuse_term.sv
      - rtl/shade_combine.sv
      - rtl/shading_unit.sv
  - target: test
    files:
      - bench/tb_shading_unit.sv

// File: bench/tb_shading_unit.sv
`timescale 1ns/1ps

module tb_shading_unit;
    import shade_pkg::*;

    localparam int PERIOD      = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_TESTS     = 6;
    // downstream credit return modes
    localparam int DS_AUTO = 0;
    localparam int DS_HOLD = 1;
    localparam int DS_RAND = 2;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    logic   in_hit;
    fp_t    in_nx, in_ny, in_nz, in_lx, in_ly, in_lz;
    logic   out_credit;
    logic   in_credit;
    logic   out_valid;
    pixel_t out_pixel;

    integer seed;
    // separate stream for credit returns
    integer credit_seed;
    int     errors;
    int     checks;
    int     err_mark;
    int     tests_done;
    // upstream credits held by the tb
    int     up_credits;
    int     credit_pulses;
    int     out_count;
    // credits still to hand back downstream
    int     owed;
    int     ds_mode;
    time    last_acc;
    time    last_out;
    pixel_t exp_pix;
    pixel_t exp_q [$];

    shading_unit i_shading_unit (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // top fraction byte, saturating at 1.0
    function automatic chan_t expect_chan(fp_t amb, fp_t dif);
        fp_t sum;
        sum = amb + dif;
        if (sum >= FP_ONE) begin
            return 8'hff;
        end
        return sum[23:16];
    endfunction

    function automatic pixel_t expect_pixel(logic hit, fp_t nx, fp_t ny, fp_t nz,
                                            fp_t lx, fp_t ly, fp_t lz);
        fp_t level;
        fp_t lambert;
        if (!hit) begin
            return '0;
        end
        // sky level from upward part of the normal
        level   = FP_HALF + fp_mul(FP_HALF, (ny < 0) ? fp_t'(0) : ny);
        lambert = fp_dot3(nx, ny, nz, lx, ly, lz);
        if (lambert < 0) begin
            lambert = 0;
        end
        return {expect_chan(fp_mul(level, AMB_R), fp_mul(lambert, DIFF_R)),
                expect_chan(fp_mul(level, AMB_G), fp_mul(lambert, DIFF_G)),
                expect_chan(fp_mul(level, AMB_B), fp_mul(lambert, DIFF_B))};
    endfunction

    // uniform in [-1.0, 1.0]
    function automatic fp_t rand_fp();
        return fp_t'($random(seed) % (FP_ONE + 1));
    endfunction

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) begin
                up_credits++;
                credit_pulses++;
                assert (up_credits <= FIFO_DEPTH) else begin
                    $display("upstream credit returned while tb already held every slot");
                    errors++;
                end
            end
            if (out_valid) begin
                out_count++;
                last_out = $time;
                if (ds_mode != DS_HOLD) begin
                    owed++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("pixel %06h arrived with no record outstanding", out_pixel);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_pix = exp_q.pop_front();
                    checks++;
                    assert (out_pixel === exp_pix) else begin
                        $display("MISMATCH out_pixel expected %06h got %06h",
                                 exp_pix, out_pixel);
                        errors++;
                    end
                end
            end
        end
    end

    // downstream side, one credit per cycle at most
    always @(posedge clk) begin
        #1;
        out_credit = 1'b0;
        if (rst_n && owed > 0) begin
            if (ds_mode != DS_RAND || ($random(credit_seed) & 1)) begin
                out_credit = 1'b1;
                owed--;
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // mode and grants change mid-cycle, away from the credit driver
    task automatic set_credit_mode(input int mode, input int grant);
        @(negedge clk);
        #1;
        ds_mode = mode;
        owed    = owed + grant;
        idle(1);
    endtask

    // one record, only while a credit is held
    task automatic send_rec(input logic hit, input fp_t nx, input fp_t ny, input fp_t nz,
                            input fp_t lx, input fp_t ly, input fp_t lz);
        while (up_credits == 0) begin
            idle(1);
        end
        in_valid = 1'b1;
        in_hit   = hit;
        in_nx    = nx;
        in_ny    = ny;
        in_nz    = nz;
        in_lx    = lx;
        in_ly    = ly;
        in_lz    = lz;
        exp_q.push_back(expect_pixel(hit, nx, ny, nz, lx, ly, lz));
        up_credits--;
        @(posedge clk);
        last_acc = $time;
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_pixels(input int target, input int limit);
        int n;
        n = 0;
        while (out_count < target && n < limit) begin
            idle(1);
            n++;
        end
        assert (n < limit) else begin
            $display("no pixel arrived within %0d cycles", limit);
            errors++;
        end
    endtask

    // all pixels out and all credits back
    task automatic drain(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || owed != 0) && n < limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (n < limit) else begin
            $display("pipeline did not drain, %0d pixels still missing", exp_q.size());
            errors++;
        end
        idle(2);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %-16s %s, %0d errors", name,
                 (errors == err_mark) ? "passed" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    task automatic reset_state();
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (!out_valid && !in_credit) else begin
                $display("output active after reset with no input sent");
                errors++;
            end
        end
        idle(1);
        finish_test("reset_state");
    endtask

    task automatic hit_miss_stream();
        int lat_cyc;
        send_rec(1'b1, 0, 0, FP_ONE, 0, 0, FP_ONE);
        wait_pixels(out_count + 1, 20);
        // sampled half a cycle after the output edge
        lat_cyc = int'((last_out - last_acc) / PERIOD);
        checks++;
        assert (lat_cyc == 4) else begin
            $display("first pixel came %0d cycles after acceptance, not 4", lat_cyc);
            errors++;
        end
        send_rec(1'b0, FP_ONE, 0, 0, FP_ONE, 0, 0);
        send_rec(1'b1, FP_ONE, 0, 0, FP_ONE, 0, 0);
        send_rec(1'b1, FP_ONE, 0, 0, 0, FP_ONE, 0);
        send_rec(1'b0, 0, FP_ONE, 0, 0, FP_ONE, 0);
        send_rec(1'b1, 0, FP_HALF, 0, 0, 0, FP_ONE);
        drain(100);
        finish_test("hit_miss_stream");
    endtask

    task automatic facing_away();
        // negative cosine
        send_rec(1'b1, 0, 0, FP_ONE, 0, 0, -FP_ONE);
        // downward normal lit from below
        send_rec(1'b1, 0, -FP_ONE, 0, 0, -FP_ONE, 0);
        send_rec(1'b1, 0, -FP_ONE, 0, 0, FP_ONE, 0);
        drain(100);
        finish_test("facing_away");
    endtask

    task automatic saturation();
        send_rec(1'b1, 0, FP_ONE, 0, 0, FP_ONE, 0);
        send_rec(1'b1, 0, FP_ONE, 0, 0, FP_HALF, 0);
        drain(100);
        finish_test("saturation");
    endtask

    task automatic back_pressure();
        int base;
        base = out_count;
        set_credit_mode(DS_HOLD, 0);
        // distinct pixels so order shows
        for (int i = 0; i < 5; i++) begin
            send_rec(1'b1, 0, fp_t'(i * (FP_ONE / 4)), 0, 0, FP_ONE, 0);
        end
        idle(30);
        checks++;
        assert (out_count - base == OUT_CREDITS) else begin
            $display("%0d pixels came out on %0d credits", out_count - base, OUT_CREDITS);
            errors++;
        end
        for (int i = 1; i <= 5 - OUT_CREDITS; i++) begin
            set_credit_mode(DS_HOLD, 1);
            wait_pixels(base + OUT_CREDITS + i, 20);
            idle(10);
            checks++;
            assert (out_count == base + OUT_CREDITS + i) else begin
                $display("extra pixel came out after a single returned credit");
                errors++;
            end
        end
        // the two reserved credits go back
        set_credit_mode(DS_AUTO, OUT_CREDITS);
        drain(100);
        finish_test("back_pressure");
    endtask

    task automatic random_stream();
        int pulses0;
        pulses0 = credit_pulses;
        set_credit_mode(DS_RAND, 0);
        repeat (40) begin
            send_rec(1'($random(seed)), rand_fp(), rand_fp(), rand_fp(),
                     rand_fp(), rand_fp(), rand_fp());
        end
        set_credit_mode(DS_AUTO, 0);
        drain(300);
        checks++;
        assert (credit_pulses - pulses0 == 40) else begin
            $display("%0d upstream credits returned for 40 records", credit_pulses - pulses0);
            errors++;
        end
        finish_test("random_stream");
    endtask

    initial begin
        seed        = 32'h216b;
        credit_seed = seed + 1;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_hit      = 1'b0;
        in_nx       = '0;
        in_ny       = '0;
        in_nz       = '0;
        in_lx       = '0;
        in_ly       = '0;
        in_lz       = '0;
        out_credit  = 1'b0;
        up_credits  = FIFO_DEPTH;
        ds_mode     = DS_AUTO;
        owed        = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_state();
        hit_miss_stream();
        facing_away();
        saturation();
        back_pressure();
        random_stream();
        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // generous budget per test
    initial begin
        #(N_TESTS * 200 * PERIOD);
        $display("run timed out after %0d cycles", N_TESTS * 200);
        $display("Something failed");
        $finish;
    end

endmodule

// File: rtl/ambient_term.sv
`timescale 1ns/1ps

module ambient_term (
    input  logic      clk,
    input  logic      rst_n,
    hit_req_if.term   req,
    term_if.producer  amb
);
    import shade_pkg::*;

    // stage 1 state
    logic v1;
    logic hit1;
    fp_t  level1;

    // downward normals get no sky boost
    fp_t ny_pos;

    assign ny_pos = fp_clamp0(req.ny);

    // valids carry the reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            amb.valid <= 1'b0;
        end else begin
            v1        <= req.valid;
            amb.valid <= v1;
        end
    end

    // stage 1, level in [0.5, 1.0]
    always_ff @(posedge clk) begin
        if (req.valid) begin
            hit1   <= req.hit;
            level1 <= FP_HALF + fp_mul(FP_HALF, ny_pos);
        end
    end

    // stage 2, per-channel scale
    always_ff @(posedge clk) begin
        if (v1) begin
            amb.hit <= hit1;
            amb.r   <= fp_mul(level1, AMB_R);
            amb.g   <= fp_mul(level1, AMB_G);
            amb.b   <= fp_mul(level1, AMB_B);
        end
    end

endmodule

// File: rtl/diffuse_term.sv
`timescale 1ns/1ps

module diffuse_term (
    input  logic      clk,
    input  logic      rst_n,
    hit_req_if.term   req,
    term_if.producer  dif
);
    import shade_pkg::*;

    // stage 1 state
    logic v1;
    logic hit1;
    fp_t  lambert1;

    // raw cosine, may be negative
    fp_t dot_nl;

    // vectors assumed normalised upstream
    assign dot_nl = fp_dot3(req.nx, req.ny, req.nz,
                            req.lx, req.ly, req.lz);

    // same latency as the ambient branch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            dif.valid <= 1'b0;
        end else begin
            v1        <= req.valid;
            dif.valid <= v1;
        end
    end

    // stage 1
    // surfaces facing away get no diffuse light
    always_ff @(posedge clk) begin
        if (req.valid) begin
            hit1     <= req.hit;
            lambert1 <= fp_clamp0(dot_nl);
        end
    end

    // stage 2
    // per-channel diffuse colour
    always_ff @(posedge clk) begin
        if (v1) begin
            dif.hit <= hit1;
            dif.r   <= fp_mul(lambert1, DIFF_R);
            dif.g   <= fp_mul(lambert1, DIFF_G);
            dif.b   <= fp_mul(lambert1, DIFF_B);
        end
    end

endmodule

// File: rtl/hit_dispatch.sv
`timescale 1ns/1ps

module hit_dispatch #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic            in_hit,
    input  shade_pkg::fp_t  in_nx,
    input  shade_pkg::fp_t  in_ny,
    input  shade_pkg::fp_t  in_nz,
    input  shade_pkg::fp_t  in_lx,
    input  shade_pkg::fp_t  in_ly,
    input  shade_pkg::fp_t  in_lz,
    input  logic            out_credit,
    output logic            in_credit,
    hit_req_if.dispatch     req
);
    import shade_pkg::*;

    localparam int FP_W    = $bits(fp_t);
    // hit flag plus six components
    localparam int ENTRY_W = 1 + 6 * FP_W;
    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
    localparam int CRD_W   = $clog2(OUT_CREDITS + 1);

    // record storage, no reset
    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [ENTRY_W-1:0] rd_entry;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // downstream credits still available
    logic [CRD_W-1:0] credits;

    logic push;
    logic pop;

    // full buffer drops the record, upstream broke the credit rule
    assign push = in_valid && (count != CNT_W'(FIFO_DEPTH));
    // a credit is reserved here for the whole pipeline
    assign pop  = (count != '0) && (credits != '0);

    assign rd_entry = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {in_hit, in_nx, in_ny, in_nz, in_lx, in_ly, in_lz};
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // wrap for any depth, not only powers of two
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // credit counter
    // spend and return in one cycle cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CRD_W'(OUT_CREDITS);
        end else begin
            case ({pop, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // issue and upstream credit go out together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            req.valid <= pop;
            in_credit <= pop;
        end
    end

    // payload only loads on a pop
    always_ff @(posedge clk) begin
        if (pop) begin
            {req.hit, req.nx, req.ny, req.nz, req.lx, req.ly, req.lz} <= rd_entry;
        end
    end

endmodule

// File: rtl/shade_combine.sv
`timescale 1ns/1ps

module shade_combine (
    input  logic              clk,
    input  logic              rst_n,
    term_if.consumer          amb,
    term_if.consumer          dif,
    output logic              out_valid,
    output shade_pkg::pixel_t out_pixel
);
    import shade_pkg::*;

    chan_t r_chan, g_chan, b_chan;

    // 1.0 or above saturates
    // otherwise top fraction byte
    function automatic chan_t to_chan(fp_t a, fp_t b);
        fp_t sum;
        sum = a + b;
        return (sum >= FP_ONE) ? CHAN_MAX : sum[23:16];
    endfunction

    assign r_chan = to_chan(amb.r, dif.r);
    assign g_chan = to_chan(amb.g, dif.g);
    assign b_chan = to_chan(amb.b, dif.b);

    // branches run in lockstep, ambient valid stands for both
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= amb.valid;
        end
    end

    // misses go out black
    always_ff @(posedge clk) begin
        if (amb.valid) begin
            out_pixel <= amb.hit ? {r_chan, g_chan, b_chan} : '0;
        end
    end

endmodule

// File: rtl/shade_if.sv
`timescale 1ns/1ps

// issued hit record, dispatch to both branches
// no ready, a valid cycle is always taken
interface hit_req_if;
    import shade_pkg::*;

    logic valid;
    logic hit;
    // surface normal
    fp_t  nx, ny, nz;
    // light direction
    fp_t  lx, ly, lz;

    modport dispatch (output valid, hit, nx, ny, nz, lx, ly, lz);
    modport term     (input  valid, hit, nx, ny, nz, lx, ly, lz);
endinterface

// per-branch colour terms into the combiner
interface term_if;
    import shade_pkg::*;

    logic valid;
    logic hit;
    // unclamped channel terms
    fp_t  r, g, b;

    modport producer (output valid, hit, r, g, b);
    modport consumer (input  valid, hit, r, g, b);
endinterface

// File: rtl/shade_pkg.sv
package shade_pkg;

    // signed Q8.24 fixed point
    typedef logic signed [31:0] fp_t;

    // one colour channel
    typedef logic [7:0] chan_t;

    // packed pixel, red in the top byte
    typedef logic [23:0] pixel_t;

    // number of fraction bits in fp_t
    localparam int FP_FRAC = 24;

    localparam fp_t FP_ONE  = 32'sh0100_0000;
    localparam fp_t FP_HALF = 32'sh0080_0000;

    // ambient coefficients
    // 0.2
    localparam fp_t AMB_R = 32'sh0033_3333;
    // 0.3, rounded up
    localparam fp_t AMB_G = 32'sh004c_cccd;
    // 0.4
    localparam fp_t AMB_B = 32'sh0066_6666;

    // diffuse coefficients
    // 0.8, rounded up
    localparam fp_t DIFF_R = 32'sh00cc_cccd;
    // 0.7
    localparam fp_t DIFF_G = 32'sh00b3_3333;
    // 0.5, exact
    localparam fp_t DIFF_B = 32'sh0080_0000;

    // brightest channel value
    localparam chan_t CHAN_MAX = 8'hff;

    // signed product, back to Q8.24
    // top integer bits are simply dropped
    function automatic fp_t fp_mul(fp_t a, fp_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return fp_t'(prod >>> FP_FRAC);
    endfunction

    // three-component dot product
    // each product truncated before the sum
    function automatic fp_t fp_dot3(fp_t ax, fp_t ay, fp_t az,
                                    fp_t bx, fp_t by, fp_t bz);
        fp_t sum;
        sum = fp_mul(ax, bx);
        sum = sum + fp_mul(ay, by);
        sum = sum + fp_mul(az, bz);
        return sum;
    endfunction

    // negative values become zero
    function automatic fp_t fp_clamp0(fp_t a);
        return a[31] ? fp_t'(0) : a;
    endfunction

endpackage

// File: rtl/shading_unit.sv
`timescale 1ns/1ps

module shading_unit #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              in_hit,
    input  shade_pkg::fp_t    in_nx,
    input  shade_pkg::fp_t    in_ny,
    input  shade_pkg::fp_t    in_nz,
    input  shade_pkg::fp_t    in_lx,
    input  shade_pkg::fp_t    in_ly,
    input  shade_pkg::fp_t    in_lz,
    input  logic              out_credit,
    output logic              in_credit,
    output logic              out_valid,
    output shade_pkg::pixel_t out_pixel
);

    // issued record, fans out to both branches
    hit_req_if req_bus ();
    // branch results
    term_if    amb_bus ();
    term_if    dif_bus ();

    // buffer and both credit loops
    hit_dispatch #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_hit_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_hit     (in_hit),
        .in_nx      (in_nx),
        .in_ny      (in_ny),
        .in_nz      (in_nz),
        .in_lx      (in_lx),
        .in_ly      (in_ly),
        .in_lz      (in_lz),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .req        (req_bus.dispatch)
    );

    ambient_term i_ambient_term (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_bus.term),
        .amb   (amb_bus.producer)
    );

    diffuse_term i_diffuse_term (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_bus.term),
        .dif   (dif_bus.producer)
    );

    // sum, saturate, pack
    shade_combine i_shade_combine (
        .clk       (clk),
        .rst_n     (rst_n),
        .amb       (amb_bus.consumer),
        .dif       (dif_bus.consumer),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

// File: verilog.f
rtl/shade_pkg.sv
rtl/shade_if.sv
rtl/hit_dispatch.sv
rtl/ambient_term.sv
rtl/diffuse_term.sv
rtl/shade_combine.sv
rtl/shading_unit.sv
bench/tb_shading_unit.sv
